//--- tb.f
cachePkg.sv
cacheArray.sv
backingMemory.sv
cacheController.sv
cacheTop.sv
tbClock.sv
tbChecker.sv
tbTop.sv

//--- Makefile
# any of these can be overridden on the command line, e.g. make sim TOP=tbTop
VERILATOR ?= verilator
TOP       ?= tbTop
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= All tests passed!

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run passes only if the pass message shows up in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- tbTop.sv
`timescale 1ns/1ps

module tbTop;

    // the six tests issue 32 + 16 + 12 + 16 + 15 + 8 transfers
    localparam int NUM_TRANSFERS = 99;
    // a miss needs at most MEM_LATENCY + 6 cycles including setup and the gap after it
    localparam int WATCHDOG_NS = NUM_TRANSFERS * (cachePkg::MEM_LATENCY + 6) * 10 + 1000;

    logic           clk;
    logic           rst;
    logic           psel;
    logic           penable;
    logic           pwrite;
    cachePkg::addrT paddr;
    cachePkg::dataT pwdata;
    cachePkg::strbT pstrb;
    logic           pready;
    cachePkg::dataT prdata;
    logic           pslverr;
    logic           mustHit;
    logic           mustMiss;
    int             errorCount;
    int             doneCount;
    int             seed;

    // every address stored in full by the first test
    cachePkg::addrT written [$];

    tbClock clockGen (.clk(clk), .rst(rst));

    cacheTop DUT (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
        .pready(pready), .prdata(prdata), .pslverr(pslverr)
    );

    tbChecker compare (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
        .pready(pready), .prdata(prdata), .pslverr(pslverr),
        .mustHit(mustHit), .mustMiss(mustMiss),
        .errorCount(errorCount), .doneCount(doneCount)
    );

    function automatic cachePkg::addrT randomAddr();
        logic [7:0] word;
        word = 8'($random(seed));
        return {53'd0, word, 3'b000};
    endfunction

    function automatic cachePkg::dataT randomData();
        return {$random(seed), $random(seed)};
    endfunction

    // setup cycle, then access cycles until the slave raises pready
    task automatic apbTransfer(input logic write, input cachePkg::addrT addr,
                               input cachePkg::dataT data, input cachePkg::strbT strb,
                               input logic hitRequired, input logic missRequired);
        @(posedge clk);
        psel     <= 1'b1;
        penable  <= 1'b0;
        pwrite   <= write;
        paddr    <= addr;
        pwdata   <= data;
        pstrb    <= strb;
        mustHit  <= hitRequired;
        mustMiss <= missRequired;
        @(posedge clk);
        penable <= 1'b1;
        do begin
            @(posedge clk);
        end while (!pready);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic writeWord(input cachePkg::addrT addr, input cachePkg::dataT data,
                             input cachePkg::strbT strb);
        apbTransfer(1'b1, addr, data, strb, 1'b0, 1'b0);
    endtask

    task automatic readWord(input cachePkg::addrT addr, input logic hitRequired,
                            input logic missRequired);
        apbTransfer(1'b0, addr, '0, '0, hitRequired, missRequired);
    endtask

    initial begin : testSequence
        cachePkg::addrT  addr;
        cachePkg::addrT  conflict [3];
        cachePkg::indexT idx;
        int              pick;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        pstrb    = '0;
        mustHit  = 1'b0;
        mustMiss = 1'b0;
        seed     = 20;
        @(negedge rst);

        // full writes to random words, then read every one back
        for (int i = 0; i < 16; i++) begin
            addr = randomAddr();
            written.push_back(addr);
            writeWord(addr, randomData(), 8'hff);
        end
        foreach (written[i]) begin
            readWord(written[i], 1'b0, 1'b0);
        end

        // partial strobes merge into the old word, and the store drops the set
        for (int i = 0; i < 8; i++) begin
            writeWord(written[i], randomData(), 8'($random(seed)));
            readWord(written[i], 1'b0, 1'b1);
        end

        // a refill makes the very next read of the same word a hit
        for (int i = 0; i < 4; i++) begin
            addr = written[i + 8];
            writeWord(addr, randomData(), 8'hff);
            readWord(addr, 1'b0, 1'b1);
            readWord(addr, 1'b1, 1'b0);
        end

        // a store to a cached word must never leave stale data behind
        for (int i = 0; i < 4; i++) begin
            addr = written[i + 4];
            readWord(addr, 1'b0, 1'b0);
            readWord(addr, 1'b1, 1'b0);
            writeWord(addr, randomData(), 8'hff);
            readWord(addr, 1'b0, 1'b1);
        end

        // three tags fight over the two ways of one set
        idx = 2'($random(seed));
        for (int k = 0; k < 3; k++) begin
            conflict[k] = {53'd0, 6'(k * 7 + 1), idx, 3'b000};
            writeWord(conflict[k], randomData(), 8'hff);
        end
        for (int i = 0; i < 12; i++) begin
            pick = {$random(seed)} % 3;
            readWord(conflict[pick], 1'b0, 1'b0);
        end

        // the far address of a rejected store would alias onto the word read back afterwards
        for (int i = 0; i < 2; i++) begin
            addr = written[i + 12];
            writeWord(addr | 64'd4, randomData(), 8'hff);
            writeWord(addr + cachePkg::ADDR_LIMIT, randomData(), 8'hff);
            if (i == 0) begin
                readWord(addr + 64'd1, 1'b0, 1'b0);
            end else begin
                readWord(addr + cachePkg::ADDR_LIMIT, 1'b0, 1'b0);
            end
            readWord(addr, 1'b0, 1'b0);
        end

        // let the checker score the last completion
        repeat (2) @(posedge clk);
        $display("transfers: %0d of %0d, errors: %0d", doneCount, NUM_TRANSFERS, errorCount);
        if (errorCount == 0 && doneCount == NUM_TRANSFERS) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: tests still running after %0d ns, %0d transfers done, %0d errors",
                 WATCHDOG_NS, doneCount, errorCount);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- tbChecker.sv
`timescale 1ns/1ps

module tbChecker (
    input  logic           clk,
    input  logic           rst,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  cachePkg::addrT paddr,
    input  cachePkg::dataT pwdata,
    input  cachePkg::strbT pstrb,
    input  logic           pready,
    input  cachePkg::dataT prdata,
    input  logic           pslverr,
    input  logic           mustHit,
    input  logic           mustMiss,
    output int             errorCount,
    output int             doneCount
);

    // expected content of every doubleword the testbench has stored
    cachePkg::dataT refMem [cachePkg::addrT];

    // cycles the current access phase has been stretched so far
    int waitCycles;

    // only the strobed byte lanes take the new data
    function automatic cachePkg::dataT mergeBytes(cachePkg::dataT oldData,
                                                  cachePkg::dataT newData,
                                                  cachePkg::strbT strb);
        cachePkg::dataT merged;
        merged = oldData;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = newData[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // the slave must refuse anything misaligned or past the end of memory
    function automatic logic expectError(cachePkg::addrT addr);
        return (addr >= cachePkg::ADDR_LIMIT) || (addr[2:0] != 3'b000);
    endfunction

    // values read here are the ones held during the cycle that just ended
    always @(posedge clk) begin : watchApb
        logic           badAddr;
        cachePkg::dataT oldData;
        if (rst) begin
            waitCycles = 0;
            errorCount = 0;
            doneCount  = 0;
        end else if (psel && penable && !pready) begin
            waitCycles = waitCycles + 1;
        end else if (psel && penable) begin
            badAddr   = expectError(paddr);
            doneCount = doneCount + 1;
            if (pslverr !== badAddr) begin
                $display("FAIL pslverr at paddr 0x%h: got 0x%h, expected 0x%h",
                         paddr, pslverr, badAddr);
                errorCount = errorCount + 1;
            end
            if (!badAddr && pwrite) begin
                // partial writes are only aimed at words that were written in full before
                oldData = refMem.exists(paddr) ? refMem[paddr] : '0;
                refMem[paddr] = mergeBytes(oldData, pwdata, pstrb);
            end else if (!badAddr) begin
                if (!refMem.exists(paddr)) begin
                    $display("read of 0x%h, which no earlier write has defined", paddr);
                    errorCount = errorCount + 1;
                end else if (prdata !== refMem[paddr]) begin
                    $display("FAIL prdata at paddr 0x%h: got 0x%h, expected 0x%h",
                             paddr, prdata, refMem[paddr]);
                    errorCount = errorCount + 1;
                end
                if (mustHit && waitCycles != 0) begin
                    $display("read of 0x%h should hit but took %0d wait states",
                             paddr, waitCycles);
                    errorCount = errorCount + 1;
                end
                if (mustMiss && waitCycles == 0) begin
                    $display("read of 0x%h completed at once although its line was dropped",
                             paddr);
                    errorCount = errorCount + 1;
                end
            end
            waitCycles = 0;
        end
    end

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset stays high across the first three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- cacheTop.sv
`timescale 1ns/1ps

module cacheTop (
    input  logic           clk,
    input  logic           rst,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  cachePkg::addrT paddr,
    input  cachePkg::dataT pwdata,
    input  cachePkg::strbT pstrb,
    output logic           pready,
    output cachePkg::dataT prdata,
    output logic           pslverr
);

    // controller to array
    cachePkg::addrT lookupAddr;
    logic           hit;
    cachePkg::dataT hitData;
    logic           fillValid;
    cachePkg::addrT fillAddr;
    cachePkg::dataT fillData;
    logic           invalValid;
    cachePkg::addrT invalAddr;

    // controller to memory
    logic           memReq;
    logic           memWrite;
    cachePkg::addrT memAddr;
    cachePkg::dataT memWdata;
    cachePkg::strbT memStrb;
    logic           memRvalid;
    cachePkg::dataT memRdata;

    cacheController ctrl (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
        .pready(pready), .prdata(prdata), .pslverr(pslverr),
        .lookupAddr(lookupAddr), .hit(hit), .hitData(hitData),
        .fillValid(fillValid), .fillAddr(fillAddr), .fillData(fillData),
        .invalValid(invalValid), .invalAddr(invalAddr),
        .memReq(memReq), .memWrite(memWrite), .memAddr(memAddr),
        .memWdata(memWdata), .memStrb(memStrb),
        .memRvalid(memRvalid), .memRdata(memRdata)
    );

    cacheArray array (
        .clk(clk), .rst(rst),
        .lookupAddr(lookupAddr), .hit(hit), .hitData(hitData),
        .fillValid(fillValid), .fillAddr(fillAddr), .fillData(fillData),
        .invalValid(invalValid), .invalAddr(invalAddr)
    );

    // fixed-latency store behind the write-through cache
    backingMemory memory (
        .clk(clk), .rst(rst),
        .memReq(memReq), .memWrite(memWrite), .memAddr(memAddr),
        .memWdata(memWdata), .memStrb(memStrb),
        .memRvalid(memRvalid), .memRdata(memRdata)
    );

endmodule

//--- cacheController.sv
`timescale 1ns/1ps

module cacheController (
    input  logic           clk,
    input  logic           rst,

    // APB4 slave side
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  cachePkg::addrT paddr,
    input  cachePkg::dataT pwdata,
    input  cachePkg::strbT pstrb,
    output logic           pready,
    output cachePkg::dataT prdata,
    output logic           pslverr,

    // cache array side
    output cachePkg::addrT lookupAddr,
    input  logic           hit,
    input  cachePkg::dataT hitData,
    output logic           fillValid,
    output cachePkg::addrT fillAddr,
    output cachePkg::dataT fillData,
    output logic           invalValid,
    output cachePkg::addrT invalAddr,

    // backing memory side
    output logic           memReq,
    output logic           memWrite,
    output cachePkg::addrT memAddr,
    output cachePkg::dataT memWdata,
    output cachePkg::strbT memStrb,
    input  logic           memRvalid,
    input  cachePkg::dataT memRdata
);

    cachePkg::ctrlStateT state;
    cachePkg::ctrlStateT nextState;

    logic           accessCycle;
    logic           addrErr;
    logic           reqErr;
    cachePkg::dataT refillData;

    // psel and penable together mark the access phase of a transfer
    assign accessCycle = psel && penable;

    // out of range or not doubleword aligned
    assign addrErr = (paddr >= cachePkg::ADDR_LIMIT) || (paddr[2:0] != 3'b000);

    always_comb begin
        nextState = state;
        unique case (state)
            cachePkg::IDLE: begin
                // a clean read hit finishes here and the FSM stays put
                if (accessCycle) begin
                    if (addrErr) begin
                        nextState = cachePkg::RESPOND;
                    end else if (pwrite) begin
                        nextState = cachePkg::WRITE_WAIT;
                    end else if (!hit) begin
                        nextState = cachePkg::LOOKUP;
                    end
                end
            end
            // issues the read pulse for the missing doubleword
            cachePkg::LOOKUP:     nextState = cachePkg::MISS_WAIT;
            cachePkg::MISS_WAIT: begin
                if (memRvalid) begin
                    nextState = cachePkg::REFILL;
                end
            end
            cachePkg::REFILL:     nextState = cachePkg::RESPOND;
            cachePkg::WRITE_WAIT: nextState = cachePkg::RESPOND;
            cachePkg::RESPOND:    nextState = cachePkg::IDLE;
            default:              nextState = cachePkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= cachePkg::IDLE;
            reqErr <= 1'b0;
        end else begin
            state <= nextState;
            // the error verdict is taken once, when the transfer is accepted
            if (state == cachePkg::IDLE && accessCycle) begin
                reqErr <= addrErr;
            end
        end
    end

    // the returned word feeds the refill and later prdata
    always_ff @(posedge clk) begin
        if (state == cachePkg::MISS_WAIT && memRvalid) begin
            refillData <= memRdata;
        end
    end

    // a hit needs zero wait states and every other transfer gets pready from RESPOND
    assign pready = (state == cachePkg::IDLE && accessCycle && !pwrite && !addrErr && hit)
                    || (state == cachePkg::RESPOND);
    assign pslverr = (state == cachePkg::RESPOND) && reqErr;
    assign prdata  = (state == cachePkg::IDLE) ? hitData : refillData;

    // the master holds paddr and the write payload until pready, so they are used directly
    assign lookupAddr = paddr;
    assign fillAddr   = paddr;
    assign invalAddr  = paddr;
    assign memAddr    = paddr;
    assign memWdata   = pwdata;
    assign memStrb    = pstrb;
    assign fillData   = refillData;

    // single-cycle pulses straight from the state
    assign memReq     = (state == cachePkg::LOOKUP) || (state == cachePkg::WRITE_WAIT);
    assign memWrite   = (state == cachePkg::WRITE_WAIT);
    // a write-through store simply drops its set from the cache
    assign invalValid = (state == cachePkg::WRITE_WAIT);
    assign fillValid  = (state == cachePkg::REFILL);

    // a completion outside an access phase would break the APB handshake with the master
    assert property (@(posedge clk) disable iff (rst)
        pready |-> (psel && penable))
        else $error("cacheController: pready outside an APB access phase");

endmodule

//--- backingMemory.sv
`timescale 1ns/1ps

module backingMemory (
    input  logic           clk,
    input  logic           rst,
    input  logic           memReq,
    input  logic           memWrite,
    input  cachePkg::addrT memAddr,
    input  cachePkg::dataT memWdata,
    input  cachePkg::strbT memStrb,
    output logic           memRvalid,
    output cachePkg::dataT memRdata
);

    cachePkg::dataT     mem [cachePkg::MEM_WORDS];
    cachePkg::memIndexT reqIdx;

    // the last stage of the read pipeline drives the outputs
    logic [cachePkg::MEM_LATENCY-1:0] rdValid;
    cachePkg::memIndexT               rdIdx [cachePkg::MEM_LATENCY];

    // upper address bits are out of range here and are checked by the controller
    assign reqIdx = memAddr[10:3];

    // writes land at the edge of the request pulse, lane by lane
    always_ff @(posedge clk) begin
        if (memReq && memWrite) begin
            for (int b = 0; b < $bits(cachePkg::strbT); b++) begin
                if (memStrb[b]) begin
                    mem[reqIdx][8*b +: 8] <= memWdata[8*b +: 8];
                end
            end
        end
    end

    // valid flags shift one stage per cycle so reads can start back to back
    always_ff @(posedge clk) begin
        if (rst) begin
            rdValid <= '0;
        end else begin
            rdValid <= {rdValid[cachePkg::MEM_LATENCY-2:0], memReq && !memWrite};
        end
    end

    // the word index travels alongside its valid flag
    always_ff @(posedge clk) begin
        rdIdx[0] <= reqIdx;
        for (int s = 1; s < cachePkg::MEM_LATENCY; s++) begin
            rdIdx[s] <= rdIdx[s-1];
        end
    end

    // array is read at the last stage, so a write issued meanwhile is visible
    assign memRvalid = rdValid[cachePkg::MEM_LATENCY-1];
    assign memRdata  = mem[rdIdx[cachePkg::MEM_LATENCY-1]];

    // every response must trace back to exactly one read pulse
    assert property (@(posedge clk) disable iff (rst)
        memRvalid |-> $past(memReq && !memWrite, cachePkg::MEM_LATENCY))
        else $error("backingMemory: memRvalid without a read %0d cycles earlier",
                    cachePkg::MEM_LATENCY);

endmodule

//--- cacheArray.sv
`timescale 1ns/1ps

module cacheArray (
    input  logic           clk,
    input  logic           rst,
    input  cachePkg::addrT lookupAddr,
    output logic           hit,
    output cachePkg::dataT hitData,
    input  logic           fillValid,
    input  cachePkg::addrT fillAddr,
    input  cachePkg::dataT fillData,
    input  logic           invalValid,
    input  cachePkg::addrT invalAddr
);

    // per-set state of way 0 and way 1
    logic           valid0 [cachePkg::NUM_SETS];
    logic           valid1 [cachePkg::NUM_SETS];
    cachePkg::tagT  tag0 [cachePkg::NUM_SETS];
    cachePkg::tagT  tag1 [cachePkg::NUM_SETS];
    cachePkg::dataT data0 [cachePkg::NUM_SETS];
    cachePkg::dataT data1 [cachePkg::NUM_SETS];

    // toggles on every refill of a set and steers the next victim
    logic           toggle [cachePkg::NUM_SETS];

    cachePkg::indexT lookIdx;
    cachePkg::indexT fillIdx;
    cachePkg::indexT invalIdx;
    cachePkg::tagT   lookTag;
    cachePkg::tagT   fillTag;
    logic            match0;
    logic            match1;
    logic            fillWay0;

    assign lookIdx  = lookupAddr[4:3];
    assign lookTag  = lookupAddr[63:5];
    assign fillIdx  = fillAddr[4:3];
    assign fillTag  = fillAddr[63:5];
    // only the set matters for an invalidate because both ways are dropped
    assign invalIdx = invalAddr[4:3];

    // lookup is purely combinational so a hit can answer in the access cycle
    assign match0 = valid0[lookIdx] && (tag0[lookIdx] == lookTag);
    assign match1 = valid1[lookIdx] && (tag1[lookIdx] == lookTag);
    assign hit    = match0 || match1;

    always_comb begin
        if (match0) begin
            hitData = data0[lookIdx];
        end else if (match1) begin
            hitData = data1[lookIdx];
        end else begin
            hitData = '0;
        end
    end

    // way 0 takes the fill when the toggle points at it or its old tag matches,
    // but never if way 1 already carries this tag
    // stale tags count here too, which keeps one tag from landing in both ways
    assign fillWay0 = (toggle[fillIdx] || (tag0[fillIdx] == fillTag))
                      && (tag1[fillIdx] != fillTag);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cachePkg::NUM_SETS; s++) begin
                valid0[s] <= 1'b0;
                valid1[s] <= 1'b0;
                tag0[s]   <= '0;
                tag1[s]   <= '0;
                toggle[s] <= 1'b0;
            end
        end else begin
            if (fillValid) begin
                if (fillWay0) begin
                    valid0[fillIdx] <= 1'b1;
                    tag0[fillIdx]   <= fillTag;
                end else begin
                    valid1[fillIdx] <= 1'b1;
                    tag1[fillIdx]   <= fillTag;
                end
                toggle[fillIdx] <= ~toggle[fillIdx];
            end
            // placed after the fill so a store to the same set wins the cycle
            if (invalValid) begin
                valid0[invalIdx] <= 1'b0;
                valid1[invalIdx] <= 1'b0;
            end
        end
    end

    // the line payload only means something while the matching valid bit is set
    always_ff @(posedge clk) begin
        if (fillValid) begin
            if (fillWay0) begin
                data0[fillIdx] <= fillData;
            end else begin
                data1[fillIdx] <= fillData;
            end
        end
    end

    // a duplicate tag would make the hit mux pick one of two copies
    for (genvar s = 0; s < cachePkg::NUM_SETS; s++) begin : gSetCheck
        assert property (@(posedge clk) disable iff (rst)
            !(valid0[s] && valid1[s] && (tag0[s] == tag1[s])))
            else $error("cacheArray: set %0d holds the same tag in both ways", s);
    end

endmodule

//--- cachePkg.sv
package cachePkg;

    // byte address as the CPU drives it on paddr
    typedef logic [63:0] addrT;

    // one cache line and one memory word hold a single doubleword
    typedef logic [63:0] dataT;

    // one strobe bit per byte lane of a doubleword
    typedef logic [7:0] strbT;

    // tag is address bits 63 to 5, index is bits 4 to 3
    typedef logic [58:0] tagT;
    typedef logic [1:0] indexT;

    // word index into backing memory, address bits 10 to 3
    typedef logic [7:0] memIndexT;

    localparam int NUM_SETS = 4;
    localparam int MEM_WORDS = 256;

    // cycles from a read pulse to memRvalid
    localparam int MEM_LATENCY = 3;

    // first byte address that no longer maps onto backing memory
    localparam addrT ADDR_LIMIT = 64'd2048;

    // controller sequencing for one APB transfer
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_WAIT,
        REFILL,
        WRITE_WAIT,
        RESPOND
    } ctrlStateT;

endpackage
